/* flow_table_params.svh */
`ifndef FLOW_TABLE_PARAMS_SVH
`define FLOW_TABLE_PARAMS_SVH

// Packet field widths
`define FT_FLOW_ID_W    32
`define FT_PCIE_ADDR_W  64
`define FT_PKT_LEN_W    16

// Table geometry
`define FT_AWIDTH       4
`define FT_WAYS         4

// Multiplicative hash
`define FT_HASH_MULT    32'h9E3779B1
`define FT_SEED0        32'd0
`define FT_SEED1        32'd1
`define FT_SEED2        32'd2
`define FT_SEED3        32'd3

// Seed of way i
`define FT_WAY_SEED(i) \
    ((i) == 0 ? `FT_SEED0 : (i) == 1 ? `FT_SEED1 : (i) == 2 ? `FT_SEED2 : `FT_SEED3)

`endif

/* flow_pkg.sv */
`include "flow_table_params.svh"

package flow_pkg;

    // Flow identifier carried with each packet
    typedef logic [`FT_FLOW_ID_W-1:0] flow_id_t;

    // Host buffer address where zero means drop
    typedef logic [`FT_PCIE_ADDR_W-1:0] pcie_addr_t;

    typedef logic [`FT_PKT_LEN_W-1:0] pkt_len_t;

endpackage

/* table_pkg.sv */
`include "flow_table_params.svh"

package table_pkg;

    // Slot index within one way
    typedef logic [`FT_AWIDTH-1:0] slot_addr_t;

    // One bit per way
    typedef logic [`FT_WAYS-1:0] way_mask_t;

    typedef struct packed {
        logic                 valid;
        flow_pkg::flow_id_t   flow_id;
        flow_pkg::pcie_addr_t pcie_addr;
    } entry_t;

    typedef enum logic [2:0] {
        P_IDLE,
        P_LOOKUP,
        P_UPDATE,
        P_INSERT,
        P_FULL
    } place_state_t;

endpackage

/* flow_hash.sv */
`include "flow_table_params.svh"

module flow_hash #(
    parameter logic [31:0] SEED = 32'd0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  flow_pkg::flow_id_t    flow_id,
    input  logic                  flow_id_valid,
    output table_pkg::slot_addr_t slot,
    output logic                  slot_valid
);

    logic [31:0] prod;
    logic        prod_valid;
    logic [15:0] folded;

    // Fold upper half into lower half
    assign folded = prod[31:16] ^ prod[15:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
            slot_valid <= 1'b0;
        end else if (!stall) begin
            prod_valid <= flow_id_valid;
            slot_valid <= prod_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            // Low 32 bits of the seeded product
            prod <= (flow_id ^ SEED) * `FT_HASH_MULT;
            slot <= folded[`FT_AWIDTH-1:0];
        end
    end

endmodule

/* flow_way_ram.sv */
`include "flow_table_params.svh"

module flow_way_ram (
    input  logic                  clk,
    input  logic                  a_hold,
    input  logic                  a_rden,
    input  table_pkg::slot_addr_t a_addr,
    output table_pkg::entry_t     a_q,
    input  logic                  b_rden,
    input  logic                  b_wren,
    input  table_pkg::slot_addr_t b_addr,
    input  table_pkg::entry_t     b_data,
    output table_pkg::entry_t     b_q
);

    localparam int DEPTH = 2 ** `FT_AWIDTH;

    // All slots start empty
    table_pkg::entry_t mem [DEPTH] = '{default: '0};
    table_pkg::entry_t a_r;
    table_pkg::entry_t b_r;

    // Lookup port is read only and freezes while held
    always_ff @(posedge clk) begin
        if (!a_hold) begin
            if (a_rden) begin
                a_r <= mem[a_addr];
            end
            a_q <= a_r;
        end
    end

    // Placement port
    always_ff @(posedge clk) begin
        if (b_wren) begin
            mem[b_addr] <= b_data;
        end
        if (b_rden) begin
            b_r <= mem[b_addr];
        end
        b_q <= b_r;
    end

endmodule

/* lookup_pipe.sv */
`include "flow_table_params.svh"

module lookup_pipe (
    input  logic                                 clk,
    input  logic                                 rst,
    input  flow_pkg::flow_id_t                   in_meta_flow_id,
    input  flow_pkg::pkt_len_t                   in_meta_pkt_len,
    input  logic                                 in_meta_valid,
    input  logic                                 out_meta_ready,
    output logic                                 rd_en,
    output logic                                 rd_hold,
    output table_pkg::slot_addr_t [`FT_WAYS-1:0] rd_addr,
    input  table_pkg::entry_t [`FT_WAYS-1:0]     rd_q,
    output flow_pkg::flow_id_t                   out_meta_flow_id,
    output flow_pkg::pkt_len_t                   out_meta_pkt_len,
    output flow_pkg::pcie_addr_t                 out_meta_addr,
    output logic                                 out_meta_valid
);

    // Acceptance to compare register
    localparam int DEPTH = 6;

    logic                                 stall;
    logic                                 accept;
    table_pkg::slot_addr_t [`FT_WAYS-1:0] slot;
    table_pkg::way_mask_t                 slot_valid;
    flow_pkg::flow_id_t                   meta_fid [DEPTH];
    flow_pkg::pkt_len_t                   meta_len [DEPTH];
    logic                                 rd_v1;
    logic                                 rd_v2;
    logic                                 cmp_valid;
    table_pkg::way_mask_t                 hit;
    table_pkg::way_mask_t                 hit_r;
    flow_pkg::pcie_addr_t                 way_addr_r [`FT_WAYS];
    flow_pkg::pcie_addr_t                 sel_addr;

    // Downstream backpressure freezes every stage
    assign stall   = !out_meta_ready;
    assign rd_hold = stall;
    assign accept  = in_meta_valid && out_meta_ready;

    for (genvar w = 0; w < `FT_WAYS; w++) begin : g_hash
        flow_hash #(
            .SEED (`FT_WAY_SEED(w))
        ) hash (
            .clk           (clk),
            .rst           (rst),
            .stall         (stall),
            .flow_id       (in_meta_flow_id),
            .flow_id_valid (accept),
            .slot          (slot[w]),
            .slot_valid    (slot_valid[w])
        );
    end

    // Metadata rides alongside hash and read latency
    always_ff @(posedge clk) begin
        if (!stall) begin
            meta_fid[0] <= in_meta_flow_id;
            meta_len[0] <= in_meta_pkt_len;
            for (int i = 1; i < DEPTH; i++) begin
                meta_fid[i] <= meta_fid[i-1];
                meta_len[i] <= meta_len[i-1];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `FT_WAYS; w++) begin
            hit[w] = rd_q[w].valid && (rd_q[w].flow_id == meta_fid[DEPTH-2]);
        end
    end

    // Lowest-numbered hitting way wins
    always_comb begin
        sel_addr = '0;
        for (int w = `FT_WAYS - 1; w >= 0; w--) begin
            if (hit_r[w]) begin
                sel_addr = way_addr_r[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en          <= 1'b0;
            rd_v1          <= 1'b0;
            rd_v2          <= 1'b0;
            cmp_valid      <= 1'b0;
            out_meta_valid <= 1'b0;
        end else if (!stall) begin
            rd_en          <= &slot_valid;
            rd_v1          <= rd_en;
            rd_v2          <= rd_v1;
            cmp_valid      <= rd_v2;
            out_meta_valid <= cmp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rd_addr <= slot;
            hit_r   <= hit;
            for (int w = 0; w < `FT_WAYS; w++) begin
                way_addr_r[w] <= rd_q[w].pcie_addr;
            end
            out_meta_flow_id <= meta_fid[DEPTH-1];
            out_meta_pkt_len <= meta_len[DEPTH-1];
            out_meta_addr    <= sel_addr;
        end
    end

endmodule

/* placement_fsm.sv */
`include "flow_table_params.svh"

module placement_fsm (
    input  logic                                 clk,
    input  logic                                 rst,
    input  flow_pkg::flow_id_t                   in_control_flow_id,
    input  flow_pkg::pcie_addr_t                 in_control_addr,
    input  logic                                 in_control_valid,
    output logic                                 in_control_ready,
    output logic                                 rd_en,
    output table_pkg::slot_addr_t [`FT_WAYS-1:0] addr,
    input  table_pkg::entry_t [`FT_WAYS-1:0]     q,
    output table_pkg::way_mask_t                 wr_en,
    output table_pkg::entry_t                    wr_data,
    output logic                                 out_control_done,
    output logic                                 out_control_full
);

    table_pkg::place_state_t              state;
    logic                                 busy;
    table_pkg::slot_addr_t [`FT_WAYS-1:0] slot;
    table_pkg::way_mask_t                 slot_valid;
    flow_pkg::flow_id_t                   req_fid [2];
    flow_pkg::pcie_addr_t                 req_addr [2];
    table_pkg::entry_t                    pend;
    logic                                 rd_v1;
    logic                                 rd_v2;
    table_pkg::way_mask_t                 hit;
    table_pkg::way_mask_t                 empty;
    table_pkg::way_mask_t                 hit_r;
    table_pkg::way_mask_t                 empty_r;

    assign in_control_ready = !busy;
    assign wr_data          = pend;

    // Hashes and delay line hold while a request is in service
    for (genvar w = 0; w < `FT_WAYS; w++) begin : g_hash
        flow_hash #(
            .SEED (`FT_WAY_SEED(w))
        ) hash (
            .clk           (clk),
            .rst           (rst),
            .stall         (busy),
            .flow_id       (in_control_flow_id),
            .flow_id_valid (in_control_valid && !busy),
            .slot          (slot[w]),
            .slot_valid    (slot_valid[w])
        );
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            req_fid[0]  <= in_control_flow_id;
            req_addr[0] <= in_control_addr;
            req_fid[1]  <= req_fid[0];
            req_addr[1] <= req_addr[0];
        end
    end

    always_comb begin
        for (int w = 0; w < `FT_WAYS; w++) begin
            hit[w]   = q[w].valid && (q[w].flow_id == pend.flow_id);
            empty[w] = !q[w].valid;
        end
    end

    // Pending entry, its slots and the read result masks
    always_ff @(posedge clk) begin
        if (state == table_pkg::P_IDLE && (&slot_valid)) begin
            addr           <= slot;
            pend.valid     <= 1'b1;
            pend.flow_id   <= req_fid[1];
            pend.pcie_addr <= req_addr[1];
        end
        if (state == table_pkg::P_LOOKUP && rd_v2) begin
            hit_r   <= hit;
            empty_r <= empty;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= table_pkg::P_IDLE;
            busy             <= 1'b0;
            rd_en            <= 1'b0;
            rd_v1            <= 1'b0;
            rd_v2            <= 1'b0;
            wr_en            <= '0;
            out_control_done <= 1'b0;
            out_control_full <= 1'b0;
        end else begin
            rd_en            <= 1'b0;
            rd_v1            <= rd_en;
            rd_v2            <= rd_v1;
            wr_en            <= '0;
            out_control_done <= 1'b0;
            out_control_full <= 1'b0;

            case (state)
                table_pkg::P_IDLE: begin
                    if (&slot_valid) begin
                        rd_en <= 1'b1;
                        busy  <= 1'b1;
                        state <= table_pkg::P_LOOKUP;
                    end
                end

                // Slots arrive two cycles after the read
                table_pkg::P_LOOKUP: begin
                    if (rd_v2) begin
                        if (hit != '0) begin
                            state <= table_pkg::P_UPDATE;
                        end else if (empty != '0) begin
                            state <= table_pkg::P_INSERT;
                        end else begin
                            state <= table_pkg::P_FULL;
                        end
                    end
                end

                table_pkg::P_UPDATE, table_pkg::P_INSERT, table_pkg::P_FULL: begin
                    out_control_done <= 1'b1;
                    busy             <= 1'b0;
                    state            <= table_pkg::P_IDLE;
                    // Lowest set bit picks the way
                    if (state == table_pkg::P_UPDATE) begin
                        wr_en <= hit_r & (~hit_r + 1'b1);
                    end else if (state == table_pkg::P_INSERT) begin
                        wr_en <= empty_r & (~empty_r + 1'b1);
                    end else begin
                        out_control_full <= 1'b1;
                    end
                end

                default: begin
                    state <= table_pkg::P_IDLE;
                end
            endcase
        end
    end

endmodule

/* flow_table.sv */
`include "flow_table_params.svh"

module flow_table (
    input  logic                 clk,
    input  logic                 rst,
    input  flow_pkg::flow_id_t   in_meta_flow_id,
    input  flow_pkg::pkt_len_t   in_meta_pkt_len,
    input  logic                 in_meta_valid,
    output logic                 in_meta_ready,
    output flow_pkg::flow_id_t   out_meta_flow_id,
    output flow_pkg::pkt_len_t   out_meta_pkt_len,
    output flow_pkg::pcie_addr_t out_meta_addr,
    output logic                 out_meta_valid,
    input  logic                 out_meta_ready,
    input  flow_pkg::flow_id_t   in_control_flow_id,
    input  flow_pkg::pcie_addr_t in_control_addr,
    input  logic                 in_control_valid,
    output logic                 in_control_ready,
    output logic                 out_control_done,
    output logic                 out_control_full
);

    logic                                 lk_rd_en;
    logic                                 lk_rd_hold;
    table_pkg::slot_addr_t [`FT_WAYS-1:0] lk_addr;
    table_pkg::entry_t [`FT_WAYS-1:0]     lk_q;
    logic                                 pl_rd_en;
    table_pkg::slot_addr_t [`FT_WAYS-1:0] pl_addr;
    table_pkg::entry_t [`FT_WAYS-1:0]     pl_q;
    table_pkg::way_mask_t                 pl_wr_en;
    table_pkg::entry_t                    pl_wr_data;

    assign in_meta_ready = out_meta_ready;

    lookup_pipe lookup (
        .clk              (clk),
        .rst              (rst),
        .in_meta_flow_id  (in_meta_flow_id),
        .in_meta_pkt_len  (in_meta_pkt_len),
        .in_meta_valid    (in_meta_valid),
        .out_meta_ready   (out_meta_ready),
        .rd_en            (lk_rd_en),
        .rd_hold          (lk_rd_hold),
        .rd_addr          (lk_addr),
        .rd_q             (lk_q),
        .out_meta_flow_id (out_meta_flow_id),
        .out_meta_pkt_len (out_meta_pkt_len),
        .out_meta_addr    (out_meta_addr),
        .out_meta_valid   (out_meta_valid)
    );

    placement_fsm place (
        .clk                (clk),
        .rst                (rst),
        .in_control_flow_id (in_control_flow_id),
        .in_control_addr    (in_control_addr),
        .in_control_valid   (in_control_valid),
        .in_control_ready   (in_control_ready),
        .rd_en              (pl_rd_en),
        .addr               (pl_addr),
        .q                  (pl_q),
        .wr_en              (pl_wr_en),
        .wr_data            (pl_wr_data),
        .out_control_done   (out_control_done),
        .out_control_full   (out_control_full)
    );

    // Port A serves lookups, port B placement
    for (genvar w = 0; w < `FT_WAYS; w++) begin : g_way
        flow_way_ram ram (
            .clk    (clk),
            .a_hold (lk_rd_hold),
            .a_rden (lk_rd_en),
            .a_addr (lk_addr[w]),
            .a_q    (lk_q[w]),
            .b_rden (pl_rd_en),
            .b_wren (pl_wr_en[w]),
            .b_addr (pl_addr[w]),
            .b_data (pl_wr_data),
            .b_q    (pl_q[w])
        );
    end

endmodule

/* tb_flow_table_asserts.sv */
module flow_table_asserts (
    input logic                 clk,
    input logic                 rst,
    input flow_pkg::flow_id_t   out_meta_flow_id,
    input flow_pkg::pkt_len_t   out_meta_pkt_len,
    input flow_pkg::pcie_addr_t out_meta_addr,
    input logic                 out_meta_valid,
    input logic                 out_meta_ready,
    input logic                 in_control_valid,
    input logic                 in_control_ready,
    input logic                 out_control_done,
    input logic                 out_control_full
);

    int failures = 0;

    // Stalled lookup outputs keep their values
    hold_valid: assert property (@(posedge clk) disable iff (rst)
        !out_meta_ready |=> $stable(out_meta_valid))
        else begin
            $error("out_meta_valid changed while out_meta_ready was low");
            failures++;
        end

    hold_data: assert property (@(posedge clk) disable iff (rst)
        !out_meta_ready && out_meta_valid |=>
            $stable(out_meta_flow_id) && $stable(out_meta_pkt_len) && $stable(out_meta_addr))
        else begin
            $error("lookup output data changed while stalled");
            failures++;
        end

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        out_control_done |=> !out_control_done)
        else begin
            $error("out_control_done lasted more than one cycle");
            failures++;
        end

    full_with_done: assert property (@(posedge clk) disable iff (rst)
        out_control_full |-> out_control_done)
        else begin
            $error("out_control_full without out_control_done");
            failures++;
        end

    // Busy is taken two edges after acceptance and held until done
    busy_taken: assert property (@(posedge clk) disable iff (rst)
        in_control_valid && in_control_ready |-> ##3 !in_control_ready)
        else begin
            $error("in_control_ready still high after a request was accepted");
            failures++;
        end

    busy_held: assert property (@(posedge clk) disable iff (rst)
        !in_control_ready |=> !in_control_ready || out_control_done)
        else begin
            $error("in_control_ready rose before out_control_done");
            failures++;
        end

endmodule

/* tb_flow_table.sv */
`include "flow_table_params.svh"

module tb_flow_table;

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DLY       = 2;
    localparam int LOOKUP_LATENCY  = 6;
    localparam int CONTROL_LATENCY = 6;
    localparam int CONTROL_LIMIT   = 50;
    localparam int POOL_SIZE       = 40;
    localparam int SLOTS           = 1 << `FT_AWIDTH;
    localparam int MIX_ROUNDS      = 80;
    localparam int FILL_LIMIT      = 200;
    localparam int STALL_CYCLES    = 600;

    logic                 clk = 1'b0;
    logic                 rst;
    flow_pkg::flow_id_t   in_meta_flow_id;
    flow_pkg::pkt_len_t   in_meta_pkt_len;
    logic                 in_meta_valid;
    logic                 in_meta_ready;
    flow_pkg::flow_id_t   out_meta_flow_id;
    flow_pkg::pkt_len_t   out_meta_pkt_len;
    flow_pkg::pcie_addr_t out_meta_addr;
    logic                 out_meta_valid;
    logic                 out_meta_ready;
    flow_pkg::flow_id_t   in_control_flow_id;
    flow_pkg::pcie_addr_t in_control_addr;
    logic                 in_control_valid;
    logic                 in_control_ready;
    logic                 out_control_done;
    logic                 out_control_full;

    flow_pkg::flow_id_t   pool [POOL_SIZE];
    logic                 m_valid [`FT_WAYS][SLOTS];
    flow_pkg::flow_id_t   m_fid [`FT_WAYS][SLOTS];
    flow_pkg::pcie_addr_t m_addr [`FT_WAYS][SLOTS];
    flow_pkg::flow_id_t   exp_fid [$];
    flow_pkg::pkt_len_t   exp_len [$];
    flow_pkg::pcie_addr_t exp_addr [$];
    int                   exp_edge [$];
    int                   ready_edges = 0;
    int                   ops_issued = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    flow_table dut0 (.*);

    bind flow_table flow_table_asserts chk (
        .clk              (clk),
        .rst              (rst),
        .out_meta_flow_id (out_meta_flow_id),
        .out_meta_pkt_len (out_meta_pkt_len),
        .out_meta_addr    (out_meta_addr),
        .out_meta_valid   (out_meta_valid),
        .out_meta_ready   (out_meta_ready),
        .in_control_valid (in_control_valid),
        .in_control_ready (in_control_ready),
        .out_control_done (out_control_done),
        .out_control_full (out_control_full)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_addr(input string name, input flow_pkg::pcie_addr_t got,
                              input flow_pkg::pcie_addr_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_flow_id(input string name, input flow_pkg::flow_id_t got,
                                 input flow_pkg::flow_id_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_len(input string name, input flow_pkg::pkt_len_t got,
                             input flow_pkg::pkt_len_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    // Seeded multiply, fold the halves, keep the low slot bits
    function automatic table_pkg::slot_addr_t hash_slot(input flow_pkg::flow_id_t fid,
                                                        input int way);
        logic [31:0] prod;
        logic [15:0] folded;
        prod   = (fid ^ `FT_WAY_SEED(way)) * `FT_HASH_MULT;
        folded = prod[31:16] ^ prod[15:0];
        return folded[`FT_AWIDTH-1:0];
    endfunction

    function automatic flow_pkg::pcie_addr_t model_lookup(input flow_pkg::flow_id_t fid);
        table_pkg::slot_addr_t s;
        for (int w = 0; w < `FT_WAYS; w++) begin
            s = hash_slot(fid, w);
            if (m_valid[w][s] && m_fid[w][s] == fid)
                return m_addr[w][s];
        end
        return '0;
    endfunction

    // Update the first way holding the flow, else fill the first empty one
    function automatic logic model_place(input flow_pkg::flow_id_t fid,
                                         input flow_pkg::pcie_addr_t addr);
        table_pkg::slot_addr_t s;
        int                    way;
        way = -1;
        for (int w = 0; w < `FT_WAYS; w++) begin
            s = hash_slot(fid, w);
            if (way < 0 && m_valid[w][s] && m_fid[w][s] == fid)
                way = w;
        end
        for (int w = 0; w < `FT_WAYS; w++) begin
            s = hash_slot(fid, w);
            if (way < 0 && !m_valid[w][s])
                way = w;
        end
        if (way < 0)
            return 1'b1;
        s = hash_slot(fid, way);
        m_valid[way][s] = 1'b1;
        m_fid[way][s]   = fid;
        m_addr[way][s]  = addr;
        return 1'b0;
    endfunction

    // Never zero, so a hit is told apart from a drop
    function automatic flow_pkg::pcie_addr_t new_addr();
        return {$urandom, $urandom} | 64'h1;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic run_lookup(input flow_pkg::flow_id_t fid, input flow_pkg::pkt_len_t len);
        out_meta_ready  = 1'b1;
        in_meta_flow_id = fid;
        in_meta_pkt_len = len;
        in_meta_valid   = 1'b1;
        ops_issued++;
        next_cycle();
        in_meta_valid = 1'b0;
    endtask

    task automatic drain_lookups();
        out_meta_ready = 1'b1;
        while (exp_addr.size() != 0)
            next_cycle();
    endtask

    task automatic run_control(input flow_pkg::flow_id_t fid, input flow_pkg::pcie_addr_t addr,
                               output logic full);
        int cycles;
        while (!in_control_ready)
            next_cycle();
        in_control_flow_id = fid;
        in_control_addr    = addr;
        in_control_valid   = 1'b1;
        ops_issued++;
        next_cycle();
        in_control_valid = 1'b0;
        cycles = 0;
        while (!out_control_done && cycles < CONTROL_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (!out_control_done)
            stop_on_error("placement request never signalled done");
        if (cycles != CONTROL_LATENCY)
            stop_on_error($sformatf("placement done came %0d cycles after acceptance, not %0d",
                                    cycles, CONTROL_LATENCY));
        full = out_control_full;
        check_flag("out_control_full", full, model_place(fid, addr));
    endtask

    // Lookup results leave on a ready edge, new packets enter on one
    always @(posedge clk) begin : monitor
        int accepted_at;
        if (!rst)
            check_flag("in_meta_ready", in_meta_ready, out_meta_ready);
        if (!rst && out_meta_ready) begin
            if (out_meta_valid) begin
                if (exp_addr.size() == 0)
                    stop_on_error("lookup output appeared with no packet outstanding");
                accepted_at = exp_edge.pop_front();
                if (ready_edges - accepted_at != LOOKUP_LATENCY + 1)
                    stop_on_error($sformatf("lookup took %0d unstalled cycles instead of %0d",
                                            ready_edges - accepted_at - 1, LOOKUP_LATENCY));
                check_flow_id("out_meta_flow_id", out_meta_flow_id, exp_fid.pop_front());
                check_len("out_meta_pkt_len", out_meta_pkt_len, exp_len.pop_front());
                check_addr("out_meta_addr", out_meta_addr, exp_addr.pop_front());
            end
            if (in_meta_valid) begin
                exp_fid.push_back(in_meta_flow_id);
                exp_len.push_back(in_meta_pkt_len);
                exp_addr.push_back(model_lookup(in_meta_flow_id));
                exp_edge.push_back(ready_edges);
            end
            ready_edges++;
        end
    end

    // Bound assertions count their failures
    always @(posedge clk) begin
        if (dut0.chk.failures != 0)
            stop_on_error("a bound assertion failed, see the error above");
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 40 * ops_issued + 200)
                stop_on_error("timeout, the run took longer than its operations allow");
        end
    end

    initial begin : stimulus
        flow_pkg::flow_id_t fid;
        logic               full;
        int                 tries;

        void'($urandom(16932));
        rst                = 1'b1;
        in_meta_flow_id    = '0;
        in_meta_pkt_len    = '0;
        in_meta_valid      = 1'b0;
        out_meta_ready     = 1'b1;
        in_control_flow_id = '0;
        in_control_addr    = '0;
        in_control_valid   = 1'b0;
        for (int w = 0; w < `FT_WAYS; w++)
            for (int s = 0; s < SLOTS; s++)
                m_valid[w][s] = 1'b0;
        for (int i = 0; i < POOL_SIZE; i++)
            pool[i] = $urandom;
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        next_cycle();

        // Every lookup drops on an empty table
        for (int i = 0; i < 8; i++)
            run_lookup(pool[i], flow_pkg::pkt_len_t'($urandom));
        drain_lookups();

        // Insert, then update in place
        run_control(pool[0], new_addr(), full);
        run_lookup(pool[0], flow_pkg::pkt_len_t'($urandom));
        drain_lookups();
        run_control(pool[0], new_addr(), full);
        run_lookup(pool[0], flow_pkg::pkt_len_t'($urandom));
        drain_lookups();

        repeat (MIX_ROUNDS) begin
            fid = pool[$urandom_range(0, POOL_SIZE - 1)];
            run_control(fid, new_addr(), full);
            run_lookup(fid, flow_pkg::pkt_len_t'($urandom));
            run_lookup(pool[$urandom_range(0, POOL_SIZE - 1)], flow_pkg::pkt_len_t'($urandom));
            drain_lookups();
        end

        // Fresh flows until one finds all four slots taken
        full  = 1'b0;
        tries = 0;
        while (!full && tries < FILL_LIMIT) begin
            fid = $urandom;
            run_control(fid, new_addr(), full);
            tries++;
        end
        if (!full)
            stop_on_error("the table never reported full while being filled");
        run_lookup(fid, flow_pkg::pkt_len_t'($urandom));
        drain_lookups();

        // Random backpressure with many packets in flight
        repeat (STALL_CYCLES) begin
            out_meta_ready  = ($urandom_range(0, 3) != 0);
            in_meta_valid   = $urandom_range(0, 1);
            in_meta_flow_id = pool[$urandom_range(0, POOL_SIZE - 1)];
            in_meta_pkt_len = flow_pkg::pkt_len_t'($urandom);
            if (in_meta_valid && out_meta_ready)
                ops_issued++;
            next_cycle();
        end
        in_meta_valid = 1'b0;
        drain_lookups();

        if (dut0.chk.failures != 0) begin
            stop_on_error("a bound assertion failed, see the error above");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* vlog.f */
+incdir+.
flow_pkg.sv
table_pkg.sv
flow_hash.sv
flow_way_ram.sv
lookup_pipe.sv
placement_fsm.sv
flow_table.sv
tb_flow_table_asserts.sv
tb_flow_table.sv

/* Bender.yml */
package:
  name: flow_table

sources:
  - include_dirs:
      - .
    files:
      - flow_pkg.sv
      - table_pkg.sv
      - flow_hash.sv
      - flow_way_ram.sv
      - lookup_pipe.sv
      - placement_fsm.sv
      - flow_table.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_flow_table_asserts.sv
      - tb_flow_table.sv
